// ==== Bender.yml ====
package:
  name: cae_pers

sources:
  - files:
      - design/cae_pers_pkg.sv
      - design/inst_decoder.sv
      - design/aeg_regfile.sv
      - design/launch_ctrl.sv
      - design/cae_pers.sv

  - target: test
    files:
      - sim/tb_cae_pers.sv

# Top levels: cae_pers (design), tb_cae_pers (simulation)

// ==== design/aeg_regfile.sv ====
`timescale 1ns/1ps

module aeg_regfile import cae_pers_pkg::*; (
   input  logic              clk,
   input  logic              reset_per,
   input  dispatch_t         dispatch_i,
   input  logic [DATA_W-1:0] cae_data_i,
   output logic [DATA_W-1:0] ret_data_o,
   output logic              ret_vld_o,
   output logic              aeg_idx_err_o,
   output logic [DATA_W-1:0] aeg0_o
);

   logic [DATA_W-1:0]    aeg_q [NUM_AEG];
   logic [AEG_SEL_W-1:0] sel;
   logic                 idx_ok;
   logic                 wr_en;
   logic [DATA_W-1:0]    ret_data_q;
   logic                 ret_vld_q;
   logic                 idx_err_q;

   // Full index is checked, only the low bits pick the register
   assign idx_ok = dispatch_i.aeg_idx < AEG_IDX_W'(NUM_AEG);
   assign sel    = dispatch_i.aeg_idx[AEG_SEL_W-1:0];
   assign wr_en  = dispatch_i.wr && idx_ok;

   // *******************************************************************
   // Register bank
   // *******************************************************************
   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_AEG; i++) begin
         if (reset_per) begin
            aeg_q[i] <= '0;
         end else if (wr_en && (sel == AEG_SEL_W'(i))) begin
            aeg_q[i] <= cae_data_i;
         end
      end
   end

   assign aeg0_o = aeg_q[0];

   // *******************************************************************
   // Read return and index error
   // *******************************************************************
   always_ff @(posedge clk) begin
      ret_data_q <= aeg_q[sel];
   end

   always_ff @(posedge clk) begin
      if (reset_per) begin
         ret_vld_q <= 1'b0;
         idx_err_q <= 1'b0;
      end else begin
         ret_vld_q <= dispatch_i.rd && idx_ok;
         idx_err_q <= (dispatch_i.wr || dispatch_i.rd) && !idx_ok;
      end
   end

   assign ret_data_o    = ret_data_q;
   assign ret_vld_o     = ret_vld_q;
   assign aeg_idx_err_o = idx_err_q;

   // Every read answers with exactly one of data or error, never both
   a_read_answer: assert property (
      @(posedge clk) disable iff (reset_per)
      dispatch_i.rd |=> (ret_vld_o != aeg_idx_err_o)
   );

endmodule

// ==== design/cae_pers.sv ====
`timescale 1ns/1ps

module cae_pers import cae_pers_pkg::*; #(
   parameter int WDOG_W = 22
) (
   input  logic              clk,
   input  logic              reset_per,

   // Dispatch
   input  logic [INST_W-1:0] cae_inst_i,
   input  logic [DATA_W-1:0] cae_data_i,
   input  logic              cae_inst_vld_i,
   output logic [DATA_W-1:0] cae_ret_data_o,
   output logic              cae_ret_data_vld_o,
   output cae_exc_t          cae_exception_o,
   output logic              cae_idle_o,
   output logic              cae_stall_o,

   // PE chain
   output pe_inst_t          pe_inst_o,
   input  logic              pe_busy_i
);

   dispatch_t         dispatch;
   logic              unimpl_err;
   logic              aeg_idx_err;
   logic [DATA_W-1:0] aeg0;

   // *******************************************************************
   // Decode
   // *******************************************************************
   inst_decoder u_inst_decoder (
      .clk            (clk),
      .reset_per      (reset_per),
      .cae_inst_i     (cae_inst_i),
      .cae_inst_vld_i (cae_inst_vld_i),
      .dispatch_o     (dispatch),
      .unimpl_err_o   (unimpl_err)
   );

   // *******************************************************************
   // AEG bank
   // *******************************************************************
   aeg_regfile u_aeg_regfile (
      .clk           (clk),
      .reset_per     (reset_per),
      .dispatch_i    (dispatch),
      .cae_data_i    (cae_data_i),
      .ret_data_o    (cae_ret_data_o),
      .ret_vld_o     (cae_ret_data_vld_o),
      .aeg_idx_err_o (aeg_idx_err),
      .aeg0_o        (aeg0)
   );

   // *******************************************************************
   // Launch and busy tracking
   // *******************************************************************
   launch_ctrl #(
      .WDOG_W (WDOG_W)
   ) u_launch_ctrl (
      .clk        (clk),
      .reset_per  (reset_per),
      .dispatch_i (dispatch),
      .aeg0_i     (aeg0),
      .pe_busy_i  (pe_busy_i),
      .pe_inst_o  (pe_inst_o),
      .idle_o     (cae_idle_o),
      .stall_o    (cae_stall_o)
   );

   // Both error pulses line up one cycle after the strobe
   always_comb begin
      cae_exception_o.aeg_idx_err = aeg_idx_err;
      cae_exception_o.unimpl_err  = unimpl_err;
   end

endmodule

// ==== design/cae_pers_pkg.sv ====
package cae_pers_pkg;

   // *******************************************************************
   // Dispatch word and data widths
   // *******************************************************************
   localparam int INST_W    = 32;
   localparam int DATA_W    = 64;

   // AEG bank
   localparam int NUM_AEG   = 2;
   localparam int AEG_IDX_W = 18;
   localparam int AEG_SEL_W = 1;

   // Instruction fields with the index in the low bits
   localparam int OP_LSB    = 28;
   localparam int OP_W      = 4;
   localparam int CAEP_LSB  = 23;
   localparam int CAEP_W    = 5;

   // Top bit of the counter marks the busy window
   localparam int MIN_BUSY_W   = 6;
   localparam int PE_RESET_ARG = 16;

   // *******************************************************************
   // Encodings
   // *******************************************************************
   typedef enum logic [OP_W-1:0] {
      OP_AEG_WR = 4'd1,
      OP_AEG_RD = 4'd2,
      OP_CAEP   = 4'd3
   } inst_op_e;

   typedef enum logic [CAEP_W-1:0] {
      CAEP_HELLO  = 5'd0,
      CAEP_LAUNCH = 5'd1,
      CAEP_SPARE  = 5'd2
   } caep_e;

   typedef enum logic [2:0] {
      PE_CMD_NONE  = 3'd0,
      PE_CMD_RESET = 3'd1
   } pe_cmd_e;

   // Decoded instruction with every field qualified by the valid strobe
   typedef struct packed {
      logic                 wr;
      logic                 rd;
      logic                 caep_vld;
      caep_e                caep;
      logic [AEG_IDX_W-1:0] aeg_idx;
   } dispatch_t;

   typedef struct packed {
      logic aeg_idx_err;
      logic unimpl_err;
   } cae_exc_t;

   // Command word to the PE chain
   typedef struct packed {
      logic [55:0] payload;
      logic [4:0]  arg;
      pe_cmd_e     cmd;
   } pe_inst_t;

endpackage

// ==== design/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder import cae_pers_pkg::*; (
   input  logic              clk,
   input  logic              reset_per,
   input  logic [INST_W-1:0] cae_inst_i,
   input  logic              cae_inst_vld_i,
   output dispatch_t         dispatch_o,
   output logic              unimpl_err_o
);

   inst_op_e op;
   caep_e    caep;
   logic     op_known;
   logic     caep_known;
   logic     unimpl_c;
   logic     unimpl_q;

   assign op   = inst_op_e'(cae_inst_i[OP_LSB +: OP_W]);
   assign caep = caep_e'(cae_inst_i[CAEP_LSB +: CAEP_W]);

   always_comb begin
      case (op)
         OP_AEG_WR, OP_AEG_RD, OP_CAEP: op_known = 1'b1;
         default:                       op_known = 1'b0;
      endcase
      case (caep)
         CAEP_HELLO, CAEP_LAUNCH, CAEP_SPARE: caep_known = 1'b1;
         default:                             caep_known = 1'b0;
      endcase
   end

   // Fields only live while the strobe is up
   always_comb begin
      dispatch_o.wr       = cae_inst_vld_i && (op == OP_AEG_WR);
      dispatch_o.rd       = cae_inst_vld_i && (op == OP_AEG_RD);
      dispatch_o.caep_vld = cae_inst_vld_i && (op == OP_CAEP);
      dispatch_o.caep     = cae_inst_vld_i ? caep : CAEP_HELLO;
      dispatch_o.aeg_idx  = cae_inst_vld_i ? cae_inst_i[AEG_IDX_W-1:0] : '0;
   end

   assign unimpl_c = cae_inst_vld_i && (!op_known || ((op == OP_CAEP) && !caep_known));

   always_ff @(posedge clk) begin
      if (reset_per) begin
         unimpl_q <= 1'b0;
      end else begin
         unimpl_q <= unimpl_c;
      end
   end

   assign unimpl_err_o = unimpl_q;

   // Downstream blocks rely on one kind of request per strobe
   a_one_request: assert property (
      @(posedge clk) disable iff (reset_per)
      $onehot0({dispatch_o.wr, dispatch_o.rd, dispatch_o.caep_vld})
   );

endmodule

// ==== design/launch_ctrl.sv ====
`timescale 1ns/1ps

module launch_ctrl import cae_pers_pkg::*; #(
   parameter int WDOG_W = 22
) (
   input  logic              clk,
   input  logic              reset_per,
   input  dispatch_t         dispatch_i,
   input  logic [DATA_W-1:0] aeg0_i,
   input  logic              pe_busy_i,
   output pe_inst_t          pe_inst_o,
   output logic              idle_o,
   output logic              stall_o
);

   logic                  launch_c;
   logic                  send_q;
   logic [MIN_BUSY_W-1:0] min_busy_q;
   logic [MIN_BUSY_W-1:0] min_busy_d;
   logic                  reset_win_q;
   logic [WDOG_W-1:0]     wdog_q;
   logic                  wdog_fire;
   logic                  busy;
   pe_inst_t              reset_inst;
   pe_inst_t              pe_inst_d;
   pe_inst_t              pe_inst_q;

   assign launch_c = dispatch_i.caep_vld && (dispatch_i.caep == CAEP_LAUNCH);

   always_ff @(posedge clk) begin
      if (reset_per) begin
         send_q <= 1'b0;
      end else begin
         send_q <= launch_c;
      end
   end

   // *******************************************************************
   // Minimum busy window
   // *******************************************************************
   // Counts from 32 up to the wrap, top bit high the whole way
   always_comb begin
      min_busy_d = min_busy_q;
      if (send_q) begin
         min_busy_d = {1'b1, {(MIN_BUSY_W-1){1'b0}}};
      end else if (min_busy_q[MIN_BUSY_W-1]) begin
         min_busy_d = min_busy_q + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_per) begin
         min_busy_q  <= {1'b1, {(MIN_BUSY_W-1){1'b0}}};
         reset_win_q <= 1'b1;
      end else begin
         min_busy_q <= min_busy_d;
         if (!min_busy_d[MIN_BUSY_W-1]) begin
            reset_win_q <= 1'b0;
         end
      end
   end

   assign busy    = launch_c || send_q || min_busy_q[MIN_BUSY_W-1] || pe_busy_i;
   assign stall_o = busy;
   assign idle_o  = !busy;

   // *******************************************************************
   // Watchdog
   // *******************************************************************
   // A new launch restarts the count
   assign wdog_fire = wdog_q[WDOG_W-1];

   always_ff @(posedge clk) begin
      if (reset_per) begin
         wdog_q <= '0;
      end else if (!busy || launch_c || wdog_fire) begin
         wdog_q <= '0;
      end else begin
         wdog_q <= wdog_q + 1'b1;
      end
   end

   // *******************************************************************
   // PE command register
   // *******************************************************************
   always_comb begin
      reset_inst         = '0;
      reset_inst.cmd     = PE_CMD_RESET;
      reset_inst.arg     = 5'(PE_RESET_ARG);

      pe_inst_d          = '0;
      pe_inst_d.cmd      = PE_CMD_NONE;
      // Reset command wins over a pending launch
      if ((reset_win_q && min_busy_d[MIN_BUSY_W-1]) || wdog_fire) begin
         pe_inst_d = reset_inst;
      end else if (send_q) begin
         pe_inst_d = pe_inst_t'(aeg0_i);
      end
   end

   always_ff @(posedge clk) begin
      if (reset_per) begin
         pe_inst_q <= reset_inst;
      end else begin
         pe_inst_q <= pe_inst_d;
      end
   end

   assign pe_inst_o = pe_inst_q;

   // Launch clears the watchdog, so a forced reset cannot swallow a send
   a_send_vs_wdog: assert property (
      @(posedge clk) disable iff (reset_per)
      !(send_q && wdog_fire)
   );

endmodule

// ==== sim.f ====
design/cae_pers_pkg.sv
design/inst_decoder.sv
design/aeg_regfile.sv
design/launch_ctrl.sv
design/cae_pers.sv
sim/tb_cae_pers.sv

// ==== sim/tb_cae_pers.sv ====
`timescale 1ns/1ps

module tb_cae_pers import cae_pers_pkg::*; ();

   localparam int CLK_PERIOD = 40;
   // Tests take about 300 cycles, the longest wait is the watchdog test
   localparam int TIMEOUT_CYCLES = 4000;

   logic              clk;
   logic              reset_per;
   logic [INST_W-1:0] cae_inst_i;
   logic [DATA_W-1:0] cae_data_i;
   logic              cae_inst_vld_i;
   logic [DATA_W-1:0] cae_ret_data_o;
   logic              cae_ret_data_vld_o;
   cae_exc_t          cae_exception_o;
   logic              cae_idle_o;
   logic              cae_stall_o;
   pe_inst_t          pe_inst_o;
   logic              pe_busy_i;

   int                error_count;
   int                failed_tests;
   int                test_count;
   logic              strobe_stall;
   logic [DATA_W-1:0] aeg_model [2];
   pe_inst_t          reset_cmd;

   cae_pers #(
      .WDOG_W (8)
   ) u_cae_pers (
      .clk                (clk),
      .reset_per          (reset_per),
      .cae_inst_i         (cae_inst_i),
      .cae_data_i         (cae_data_i),
      .cae_inst_vld_i     (cae_inst_vld_i),
      .cae_ret_data_o     (cae_ret_data_o),
      .cae_ret_data_vld_o (cae_ret_data_vld_o),
      .cae_exception_o    (cae_exception_o),
      .cae_idle_o         (cae_idle_o),
      .cae_stall_o        (cae_stall_o),
      .pe_inst_o          (pe_inst_o),
      .pe_busy_i          (pe_busy_i)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
   end

   // *******************************************************************
   // Helpers
   // *******************************************************************
   // Opcode 31:28, caep 27:23, index 17:0
   function automatic logic [INST_W-1:0] make_inst(input logic [3:0] op,
                                                   input logic [4:0] caep,
                                                   input logic [17:0] idx);
      return {op, caep, 5'b0, idx};
   endfunction

   function automatic logic [DATA_W-1:0] rand_word();
      return {$urandom, $urandom};
   endfunction

   task automatic flag_error(input string msg);
      $display("[ERROR] %0t ns: %s", $time, msg);
      error_count++;
   endtask

   // One-cycle strobe with stall sampled in the strobe cycle
   task automatic send_inst(input logic [INST_W-1:0] inst, input logic [DATA_W-1:0] data);
      @(posedge clk);
      #2;
      cae_inst_i     = inst;
      cae_data_i     = data;
      cae_inst_vld_i = 1'b1;
      @(negedge clk);
      strobe_stall = cae_stall_o;
      @(posedge clk);
      #2;
      cae_inst_vld_i = 1'b0;
      cae_inst_i     = '0;
   endtask

   task automatic close_test(input string name, input int errors_before);
      test_count++;
      if (error_count == errors_before) begin
         $display("%s: passed", name);
      end else begin
         $display("%s: %0d error(s)", name, error_count - errors_before);
         failed_tests++;
      end
   endtask

   task automatic read_back(input int idx);
      send_inst(make_inst(4'd2, 5'd0, 18'(idx)), '0);
      @(negedge clk);
      if (cae_ret_data_vld_o !== 1'b1 || cae_ret_data_o !== aeg_model[idx]) begin
         flag_error($sformatf("AEG %0d read: vld %b data %h, expected %h", idx,
                              cae_ret_data_vld_o, cae_ret_data_o, aeg_model[idx]));
      end
      if (cae_exception_o !== '0) begin
         flag_error($sformatf("AEG %0d read raised exception %b", idx, cae_exception_o));
      end
      @(negedge clk);
      if (cae_ret_data_vld_o !== 1'b0) begin
         flag_error("return valid longer than one cycle");
      end
   endtask

   // *******************************************************************
   // Tests
   // *******************************************************************
   task automatic reset_window_check();
      int errs;
      errs = error_count;
      for (int i = 0; i < 32; i++) begin
         @(negedge clk);
         if (cae_stall_o !== 1'b1 || pe_inst_o !== reset_cmd) begin
            flag_error($sformatf("cycle %0d after reset: stall %b pe_inst %h", i,
                                 cae_stall_o, pe_inst_o));
         end
         @(posedge clk);
      end
      @(negedge clk);
      if (cae_stall_o !== 1'b0 || cae_idle_o !== 1'b1 || pe_inst_o !== '0) begin
         flag_error($sformatf("after window: stall %b idle %b pe_inst %h",
                              cae_stall_o, cae_idle_o, pe_inst_o));
      end
      close_test("reset window", errs);
   endtask

   task automatic aeg_access();
      int errs;
      errs = error_count;
      aeg_model[0] = rand_word();
      aeg_model[1] = rand_word();
      for (int i = 0; i < 2; i++) begin
         send_inst(make_inst(4'd1, 5'd0, 18'(i)), aeg_model[i]);
         @(negedge clk);
         if (cae_exception_o !== '0 || cae_ret_data_vld_o !== 1'b0) begin
            flag_error($sformatf("AEG %0d write: exception %b vld %b", i,
                                 cae_exception_o, cae_ret_data_vld_o));
         end
      end
      read_back(0);
      read_back(1);
      close_test("AEG write and read", errs);
   endtask

   task automatic bad_index();
      int errs;
      errs = error_count;
      send_inst(make_inst(4'd2, 5'd0, 18'd5), '0);
      @(negedge clk);
      if (cae_exception_o.aeg_idx_err !== 1'b1 || cae_ret_data_vld_o !== 1'b0) begin
         flag_error($sformatf("bad read: idx_err %b vld %b",
                              cae_exception_o.aeg_idx_err, cae_ret_data_vld_o));
      end
      send_inst(make_inst(4'd1, 5'd0, 18'd5), rand_word());
      @(negedge clk);
      if (cae_exception_o.aeg_idx_err !== 1'b1) begin
         flag_error("bad write raised no index error");
      end
      @(negedge clk);
      if (cae_exception_o !== '0) begin
         flag_error($sformatf("exception %b held past one cycle", cae_exception_o));
      end
      read_back(0);
      read_back(1);
      close_test("bad index", errs);
   endtask

   task automatic unimplemented_ops();
      int errs;
      errs = error_count;
      send_inst(make_inst(4'd7, 5'd0, 18'd0), '0);
      @(negedge clk);
      if (cae_exception_o.unimpl_err !== 1'b1 || cae_exception_o.aeg_idx_err !== 1'b0) begin
         flag_error($sformatf("opcode 7: exception %b", cae_exception_o));
      end
      send_inst(make_inst(4'd3, 5'd9, 18'd0), '0);
      @(negedge clk);
      if (cae_exception_o.unimpl_err !== 1'b1 || cae_exception_o.aeg_idx_err !== 1'b0) begin
         flag_error($sformatf("caep 9: exception %b", cae_exception_o));
      end
      // Hello and spare are no-ops
      for (int c = 0; c <= 2; c += 2) begin
         send_inst(make_inst(4'd3, 5'(c), 18'd0), '0);
         @(negedge clk);
         if (strobe_stall !== 1'b0 || cae_stall_o !== 1'b0 || cae_exception_o !== '0 ||
             pe_inst_o !== '0) begin
            flag_error($sformatf("caep %0d: stall %b/%b exception %b pe_inst %h", c,
                                 strobe_stall, cae_stall_o, cae_exception_o, pe_inst_o));
         end
      end
      close_test("unimplemented", errs);
   endtask

   task automatic launch_sequence();
      int                errs;
      logic [DATA_W-1:0] cmd_word;
      logic [DATA_W-1:0] exp_inst;
      logic              exp_stall;
      errs = error_count;
      cmd_word     = rand_word();
      aeg_model[0] = cmd_word;
      send_inst(make_inst(4'd1, 5'd0, 18'd0), cmd_word);
      send_inst(make_inst(4'd3, 5'd1, 18'd0), '0);
      if (strobe_stall !== 1'b1) begin
         flag_error("stall low in the launch strobe cycle");
      end
      // i counts cycles after the edge that took the strobe
      // Send pulse and window alone first, then a PE busy stretch after a gap
      for (int i = 0; i < 50; i++) begin
         @(negedge clk);
         exp_stall = (i < 33) || ((i >= 36) && (i < 48));
         exp_inst  = (i == 1) ? cmd_word : '0;
         if (cae_stall_o !== exp_stall || pe_inst_o !== exp_inst) begin
            flag_error($sformatf("launch cycle %0d: stall %b pe_inst %h, expected %b %h", i,
                                 cae_stall_o, pe_inst_o, exp_stall, exp_inst));
         end
         @(posedge clk);
         #2;
         pe_busy_i = (i >= 35) && (i < 47);
      end
      close_test("launch", errs);
   endtask

   task automatic watchdog_reset();
      int   errs;
      logic seen;
      errs = error_count;
      seen = 1'b0;
      @(posedge clk);
      #2;
      pe_busy_i = 1'b1;
      for (int i = 0; i < 140 && !seen; i++) begin
         @(negedge clk);
         if (cae_stall_o !== 1'b1) begin
            flag_error("stall dropped while PE busy");
         end
         seen = (pe_inst_o.cmd === PE_CMD_RESET);
      end
      if (!seen) begin
         $display("%0t ns: watchdog sent no reset command within 140 cycles", $time);
         error_count++;
      end else begin
         if (pe_inst_o !== reset_cmd) begin
            flag_error($sformatf("watchdog command %h, expected %h", pe_inst_o, reset_cmd));
         end
         @(negedge clk);
         if (pe_inst_o !== '0 || cae_stall_o !== 1'b1) begin
            flag_error($sformatf("after watchdog: pe_inst %h stall %b", pe_inst_o, cae_stall_o));
         end
      end
      @(posedge clk);
      #2;
      pe_busy_i = 1'b0;
      @(negedge clk);
      if (cae_stall_o !== 1'b0 || cae_idle_o !== 1'b1) begin
         flag_error("still stalled after PE busy dropped");
      end
      close_test("watchdog", errs);
   endtask

   // *******************************************************************
   // Main sequence
   // *******************************************************************
   initial begin
      int seed;
      reset_per      = 1'b1;
      cae_inst_i     = '0;
      cae_data_i     = '0;
      cae_inst_vld_i = 1'b0;
      pe_busy_i      = 1'b0;
      error_count    = 0;
      failed_tests   = 0;
      test_count     = 0;
      reset_cmd      = '0;
      reset_cmd.cmd  = PE_CMD_RESET;
      reset_cmd.arg  = 5'd16;
      seed = $urandom(69561);
      repeat (8) @(posedge clk);
      #2;
      reset_per = 1'b0;

      reset_window_check();
      aeg_access();
      bad_index();
      unimplemented_ops();
      launch_sequence();
      watchdog_reset();

      $display("Summary: %0d tests, %0d failed, %0d errors", test_count, failed_tests,
               error_count);
      if (error_count == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
